// ==== logic/classifier_pkg.sv ====
package classifier_pkg;

    //////////////////////////////////////////////////
    // Sizes

    localparam int N_FEATURES      = 8;
    localparam int N_CLASSES       = 6;
    localparam int TOP_K           = 3;
    localparam int COEFF_PER_CLASS = N_FEATURES + 1;            // Last word is the bias
    localparam int N_COEFF         = N_CLASSES * COEFF_PER_CLASS;
    localparam int SCORE_SHIFT     = 8;                          // Fraction bits of the sum

    //////////////////////////////////////////////////
    // Widths

    typedef logic signed [23:0] feature_t;
    typedef logic signed [15:0] weight_t;
    typedef logic signed [31:0] score_t;
    typedef logic signed [47:0] acc_t;                           // Full precision sum
    typedef logic [2:0]         class_id_t;
    typedef logic [3:0]         coeff_idx_t;
    typedef logic [5:0]         wb_adr_t;
    typedef logic [$clog2(TOP_K)-1:0] rank_idx_t;

    typedef feature_t [N_FEATURES-1:0] feature_vec_t;

    typedef struct packed {
        score_t    score;
        class_id_t id;
    } ranked_t;

    typedef ranked_t [TOP_K-1:0] ranked_vec_t;                   // Entry 0 is the best

    localparam score_t  SCORE_MIN  = {1'b1, {($bits(score_t) - 1){1'b0}}};
    localparam ranked_t RANK_EMPTY = '{score: SCORE_MIN, id: '0};

    //////////////////////////////////////////////////
    // Wishbone classic

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        weight_t dat;
    } wb_req_t;

    typedef struct packed {
        logic    ack;
        weight_t dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {IDLE, SCORE, RANK, DONE} seq_state_t;

endpackage

// ==== logic/coeff_store.sv ====
module coeff_store (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  classifier_pkg::wb_req_t    i_wb,
    output classifier_pkg::wb_rsp_t    o_wb,
    input  classifier_pkg::class_id_t  i_class,
    input  classifier_pkg::coeff_idx_t i_idx,
    output classifier_pkg::weight_t    o_coeff
);

    classifier_pkg::weight_t mem_r [classifier_pkg::N_COEFF];
    classifier_pkg::weight_t rd_dat_r;
    classifier_pkg::wb_adr_t mac_adr_w;
    logic                    ack_r;
    logic                    req_w;
    logic                    hit_w;

    assign req_w = i_wb.cyc && i_wb.stb && !ack_r;                 // One ack per cycle
    assign hit_w = i_wb.adr < classifier_pkg::N_COEFF;

    //////////////////////////////////////////////////
    // Host side

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_r <= 1'b0;
            for (int i = 0; i < classifier_pkg::N_COEFF; i++) begin
                mem_r[i] <= '0;
            end
        end else begin
            ack_r <= req_w;
            if (req_w && i_wb.we && hit_w) begin
                mem_r[i_wb.adr] <= i_wb.dat;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (req_w) begin
            rd_dat_r <= hit_w ? mem_r[i_wb.adr] : '0;               // Unmapped reads give zero
        end
    end

    assign o_wb = '{ack: ack_r, dat: rd_dat_r};

    //////////////////////////////////////////////////
    // Scoring side read in the same cycle

    assign mac_adr_w = classifier_pkg::wb_adr_t'(
        i_class * classifier_pkg::COEFF_PER_CLASS + i_idx);

    assign o_coeff = mem_r[mac_adr_w];

endmodule

// ==== logic/dense_mac.sv ====
module dense_mac (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_start,
    input  classifier_pkg::feature_vec_t i_features,
    output classifier_pkg::coeff_idx_t   o_idx,
    input  classifier_pkg::weight_t      i_coeff,
    output logic                         o_valid,
    output classifier_pkg::score_t       o_score
);

    classifier_pkg::coeff_idx_t idx_r;
    classifier_pkg::acc_t       acc_r;
    classifier_pkg::acc_t       prod_w;
    classifier_pkg::acc_t       sum_w;
    classifier_pkg::feature_t   feat_w;
    classifier_pkg::score_t     score_r;
    logic                       busy_r;
    logic                       valid_r;
    logic                       last_w;

    // Idle index points at the bias so the start cycle loads it
    assign feat_w = (idx_r < classifier_pkg::N_FEATURES) ? i_features[idx_r] : '0;
    assign prod_w = classifier_pkg::acc_t'(feat_w) * classifier_pkg::acc_t'(i_coeff);
    assign sum_w  = acc_r + prod_w;
    assign last_w = busy_r &&
                    (idx_r == classifier_pkg::coeff_idx_t'(classifier_pkg::N_FEATURES - 1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_r  <= 1'b0;
            valid_r <= 1'b0;
            idx_r   <= classifier_pkg::coeff_idx_t'(classifier_pkg::N_FEATURES);
        end else begin
            valid_r <= 1'b0;
            if (i_start) begin
                busy_r <= 1'b1;
                idx_r  <= '0;
            end else if (busy_r) begin
                if (last_w) begin
                    busy_r  <= 1'b0;
                    valid_r <= 1'b1;
                    idx_r   <= classifier_pkg::coeff_idx_t'(classifier_pkg::N_FEATURES);
                end else begin
                    idx_r <= idx_r + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Accumulator and result

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            acc_r <= classifier_pkg::acc_t'(i_coeff) <<< classifier_pkg::SCORE_SHIFT;
        end else if (busy_r) begin
            acc_r <= sum_w;
        end
        if (last_w) begin
            score_r <= classifier_pkg::score_t'(sum_w >>> classifier_pkg::SCORE_SHIFT);
        end
    end

    assign o_idx   = idx_r;
    assign o_valid = valid_r;
    assign o_score = score_r;

endmodule

// ==== logic/topk_ranker.sv ====
module topk_ranker (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_clear,
    input  logic                        i_insert,
    input  classifier_pkg::ranked_t     i_item,
    output logic                        o_ready,
    output classifier_pkg::ranked_vec_t o_ranked
);

    classifier_pkg::ranked_vec_t slot_r;
    classifier_pkg::ranked_t     carry_r;
    classifier_pkg::rank_idx_t   pos_r;
    logic                        active_r;
    logic                        take_w;
    logic                        last_w;

    // A displaced entry with an equal score still goes above the later class
    assign take_w = ($signed(carry_r.score) > $signed(slot_r[pos_r].score)) ||
                    ((carry_r.score == slot_r[pos_r].score) &&
                     (carry_r.id < slot_r[pos_r].id));
    assign last_w = pos_r == classifier_pkg::rank_idx_t'(classifier_pkg::TOP_K - 1);

    //////////////////////////////////////////////////
    // Slots compared one per cycle

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            slot_r   <= {classifier_pkg::TOP_K{classifier_pkg::RANK_EMPTY}};
            pos_r    <= '0;
            active_r <= 1'b0;
        end else if (i_clear) begin
            slot_r   <= {classifier_pkg::TOP_K{classifier_pkg::RANK_EMPTY}};
            pos_r    <= '0;
            active_r <= 1'b0;
        end else if (active_r) begin
            if (take_w) begin
                slot_r[pos_r] <= carry_r;                              // Swap down
            end
            if (last_w) begin
                active_r <= 1'b0;
                pos_r    <= '0;
            end else begin
                pos_r <= pos_r + 1'b1;
            end
        end else if (i_insert) begin
            active_r <= 1'b1;
            pos_r    <= '0;
        end
    end

    // The displaced entry moves on to the next slot as the carried item
    always_ff @(posedge i_clk) begin
        if (active_r) begin
            if (take_w) begin
                carry_r <= slot_r[pos_r];
            end
        end else if (i_insert) begin
            carry_r <= i_item;
        end
    end

    assign o_ready  = !active_r;
    assign o_ranked = slot_r;

endmodule

// ==== logic/classifier_seq.sv ====
module classifier_seq (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_start,
    input  classifier_pkg::feature_vec_t i_features,
    output classifier_pkg::feature_vec_t o_features,
    output classifier_pkg::class_id_t    o_class,
    output logic                         o_mac_start,
    input  logic                         i_mac_valid,
    input  classifier_pkg::score_t       i_score,
    output logic                         o_clear,
    output logic                         o_insert,
    output classifier_pkg::ranked_t      o_item,
    input  logic                         i_ranker_ready,
    output logic                         o_busy,
    output logic                         o_done
);

    classifier_pkg::seq_state_t   state_r, state_w;
    classifier_pkg::class_id_t    class_r, class_w;
    classifier_pkg::feature_vec_t features_r;
    classifier_pkg::ranked_t      item_r;
    logic mac_start_r, mac_start_w;
    logic clear_r, clear_w;
    logic insert_r, insert_w;
    logic busy_r, busy_w;
    logic done_r, done_w;
    logic accept_w;
    logic last_class_w;

    assign accept_w     = (state_r == classifier_pkg::IDLE) && i_start;
    assign last_class_w = class_r == classifier_pkg::class_id_t'(classifier_pkg::N_CLASSES - 1);

    //////////////////////////////////////////////////
    // Next state

    always_comb begin
        state_w     = state_r;
        class_w     = class_r;
        busy_w      = busy_r;
        mac_start_w = 1'b0;
        clear_w     = 1'b0;
        insert_w    = 1'b0;
        done_w      = 1'b0;

        case (state_r)
            classifier_pkg::IDLE: begin
                if (i_start) begin
                    state_w     = classifier_pkg::SCORE;
                    class_w     = '0;
                    busy_w      = 1'b1;
                    clear_w     = 1'b1;                                 // Fresh ranking per run
                    mac_start_w = 1'b1;
                end
            end
            classifier_pkg::SCORE: begin
                if (i_mac_valid) begin
                    state_w  = classifier_pkg::RANK;
                    insert_w = 1'b1;
                end
            end
            classifier_pkg::RANK: begin
                if (!insert_r && i_ranker_ready) begin                  // Insertion finished
                    if (last_class_w) begin
                        state_w = classifier_pkg::DONE;
                        busy_w  = 1'b0;
                        done_w  = 1'b1;
                    end else begin
                        state_w     = classifier_pkg::SCORE;
                        class_w     = class_r + 1'b1;
                        mac_start_w = 1'b1;
                    end
                end
            end
            default: begin
                state_w = classifier_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r     <= classifier_pkg::IDLE;
            class_r     <= '0;
            mac_start_r <= 1'b0;
            clear_r     <= 1'b0;
            insert_r    <= 1'b0;
            busy_r      <= 1'b0;
            done_r      <= 1'b0;
        end else begin
            state_r     <= state_w;
            class_r     <= class_w;
            mac_start_r <= mac_start_w;
            clear_r     <= clear_w;
            insert_r    <= insert_w;
            busy_r      <= busy_w;
            done_r      <= done_w;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept_w) begin
            features_r <= i_features;
        end
        if (state_r == classifier_pkg::SCORE && i_mac_valid) begin
            item_r <= '{score: i_score, id: class_r};
        end
    end

    assign o_features  = features_r;
    assign o_class     = class_r;
    assign o_mac_start = mac_start_r;
    assign o_clear     = clear_r;
    assign o_insert    = insert_r;
    assign o_item      = item_r;
    assign o_busy      = busy_r;
    assign o_done      = done_r;

endmodule

// ==== logic/char_classifier.sv ====
module char_classifier (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  classifier_pkg::wb_req_t      i_wb,
    output classifier_pkg::wb_rsp_t      o_wb,
    input  logic                         i_start,
    input  classifier_pkg::feature_vec_t i_features,
    output classifier_pkg::ranked_vec_t  o_ranked,
    output logic                         o_busy,
    output logic                         o_done
);

    classifier_pkg::feature_vec_t features;
    classifier_pkg::class_id_t    cur_class;
    classifier_pkg::coeff_idx_t   coeff_idx;
    classifier_pkg::weight_t      coeff;
    classifier_pkg::score_t       mac_score;
    classifier_pkg::ranked_t      rank_item;
    logic                         mac_start;
    logic                         mac_valid;
    logic                         rank_clear;
    logic                         rank_insert;
    logic                         rank_ready;

    //////////////////////////////////////////////////
    // Coefficients and scoring

    coeff_store coeff_store_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_wb    (i_wb),
        .o_wb    (o_wb),
        .i_class (cur_class),
        .i_idx   (coeff_idx),
        .o_coeff (coeff)
    );

    dense_mac dense_mac_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (mac_start),
        .i_features (features),
        .o_idx      (coeff_idx),
        .i_coeff    (coeff),
        .o_valid    (mac_valid),
        .o_score    (mac_score)
    );

    //////////////////////////////////////////////////
    // Ranking and control

    topk_ranker topk_ranker_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_clear  (rank_clear),
        .i_insert (rank_insert),
        .i_item   (rank_item),
        .o_ready  (rank_ready),
        .o_ranked (o_ranked)
    );

    classifier_seq classifier_seq_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_start        (i_start),
        .i_features     (i_features),
        .o_features     (features),
        .o_class        (cur_class),
        .o_mac_start    (mac_start),
        .i_mac_valid    (mac_valid),
        .i_score        (mac_score),
        .o_clear        (rank_clear),
        .o_insert       (rank_insert),
        .o_item         (rank_item),
        .i_ranker_ready (rank_ready),
        .o_busy         (o_busy),
        .o_done         (o_done)
    );

endmodule

// ==== dv/char_classifier_asserts.sv ====
module char_classifier_asserts (
    input logic                    i_clk,
    input logic                    i_rst_n,
    input classifier_pkg::wb_req_t i_wb,
    input classifier_pkg::wb_rsp_t o_wb,
    input logic                    o_busy,
    input logic                    o_done
);

    //////////////////////////////////////////////////
    // Wishbone handshake

    // The host holds cyc and stb until it has seen ack
    ack_with_request: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_wb.ack |-> (i_wb.cyc && i_wb.stb)
    ) else $error("Wishbone ack seen without cyc and stb");

    //////////////////////////////////////////////////
    // Completion

    done_single_cycle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_done |=> !o_done
    ) else $error("o_done stayed high for more than one cycle");

    busy_low_after_done: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_done |=> !o_busy
    ) else $error("o_busy high in the cycle after o_done");

endmodule

bind char_classifier char_classifier_asserts char_classifier_asserts_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_wb    (i_wb),
    .o_wb    (o_wb),
    .o_busy  (o_busy),
    .o_done  (o_done)
);

// ==== dv/tb_char_classifier.sv ====
module tb_char_classifier;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 4;
    localparam int          N_TESTS      = 6;
    localparam int          RUN_BOUND    = 800;                     // Cycles for one row with writes
    localparam int          ACK_BOUND    = 16;
    localparam logic [31:0] LFSR_SEED    = 32'h8e88_0de8;
    localparam logic [31:0] LFSR_TAPS    = 32'hb4bc_d35c;

    typedef enum {C_KEEP, C_RANDOM, C_BIAS, C_TIE} coeff_mode_e;
    typedef enum {F_RANDOM, F_EXTREME} feat_mode_e;

    typedef struct {
        string       name;
        coeff_mode_e coeff;
        feat_mode_e  feat;
    } test_row_t;

    logic                         i_clk;
    logic                         i_rst_n;
    classifier_pkg::wb_req_t      i_wb;
    classifier_pkg::wb_rsp_t      o_wb;
    logic                         i_start;
    classifier_pkg::feature_vec_t i_features;
    classifier_pkg::ranked_vec_t  o_ranked;
    logic                         o_busy;
    logic                         o_done;

    test_row_t                   tests [N_TESTS];
    string                       test_name;
    logic [31:0]                 lfsr;
    classifier_pkg::weight_t     coeff_m [classifier_pkg::N_COEFF];  // Model copy of the store
    classifier_pkg::feature_t    feat_m [classifier_pkg::N_FEATURES];
    classifier_pkg::ranked_vec_t last_rank;
    logic                        have_last;

    char_classifier char_classifier_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wb       (i_wb),
        .o_wb       (o_wb),
        .i_start    (i_start),
        .i_features (i_features),
        .o_ranked   (o_ranked),
        .o_busy     (o_busy),
        .o_done     (o_done)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        #((N_TESTS * RUN_BOUND + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("Something failed");
        $fatal(1, "Timeout: the tests did not finish in the allowed time");
    end

    //////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check(input string what, input logic [47:0] expected,
                         input logic [47:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s (%s): expected %0h, actual %0h",
                     test_name, what, expected, actual);
            $display("Something failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("Something failed");
        $fatal(1, "%s in test %s", why, test_name);
    endtask

    // Score rule at full precision, then shifted and cut to 32 bits
    function automatic classifier_pkg::score_t model_score(input int c);
        longint acc;
        int     base;
        base = c * classifier_pkg::COEFF_PER_CLASS;
        acc  = longint'(coeff_m[base + classifier_pkg::N_FEATURES]) * 256;
        for (int j = 0; j < classifier_pkg::N_FEATURES; j++) begin
            acc += longint'(feat_m[j]) * longint'(coeff_m[base + j]);
        end
        return classifier_pkg::score_t'(acc >>> classifier_pkg::SCORE_SHIFT);
    endfunction

    // Pick the best remaining class each time so the first one wins a tie
    function automatic classifier_pkg::ranked_vec_t rank_model();
        classifier_pkg::ranked_vec_t r;
        classifier_pkg::score_t      s [classifier_pkg::N_CLASSES];
        logic                        taken [classifier_pkg::N_CLASSES];
        int                          best;
        for (int c = 0; c < classifier_pkg::N_CLASSES; c++) begin
            s[c]     = model_score(c);
            taken[c] = 1'b0;
        end
        for (int k = 0; k < classifier_pkg::TOP_K; k++) begin
            best = -1;
            for (int c = 0; c < classifier_pkg::N_CLASSES; c++) begin
                if (!taken[c] && (best < 0 || s[c] > s[best])) begin
                    best = c;
                end
            end
            taken[best] = 1'b1;
            r[k]        = '{score: s[best], id: classifier_pkg::class_id_t'(best)};
        end
        return r;
    endfunction

    //////////////////////////////////////////////////
    // Bus and run tasks

    // Called on a falling edge, returns on a falling edge
    task automatic wb_transfer(input logic we, input classifier_pkg::wb_adr_t adr,
                               input classifier_pkg::weight_t dat,
                               output classifier_pkg::weight_t rdat);
        int waited;
        i_wb   = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        waited = 0;
        do begin
            @(negedge i_clk);
            waited++;
        end while (!o_wb.ack && waited < ACK_BOUND);
        if (!o_wb.ack) begin
            abort_run("Wishbone ack never came");
        end
        rdat = o_wb.dat;
        @(negedge i_clk);                                           // Request held past the ack edge
        i_wb = '0;
    endtask

    task automatic load_coeffs(input coeff_mode_e mode);
        logic [31:0]             bits;
        classifier_pkg::weight_t word;
        classifier_pkg::weight_t rdat;
        int                      adr;
        for (int c = 0; c < classifier_pkg::N_CLASSES; c++) begin
            for (int i = 0; i < classifier_pkg::COEFF_PER_CLASS; i++) begin
                adr = c * classifier_pkg::COEFF_PER_CLASS + i;
                case (mode)
                    C_RANDOM: begin
                        random_bits(16, bits);
                        word = bits[15:0];
                    end
                    C_BIAS: begin
                        word = (i == classifier_pkg::N_FEATURES) ?
                               classifier_pkg::weight_t'(((c * 37) % 11) * 100 - 400) : '0;
                    end
                    default: begin                                  // Same weights with tied biases
                        if (i == classifier_pkg::N_FEATURES) begin
                            word = (c == 3) ? 16'sd120 :
                                   ((c == 2 || c == 5) ? -16'sd40 : 16'sd40);
                        end else begin
                            word = classifier_pkg::weight_t'(i * 5 - 17);
                        end
                    end
                endcase
                coeff_m[adr] = word;
                wb_transfer(1'b1, classifier_pkg::wb_adr_t'(adr), word, rdat);
            end
        end
    endtask

    task automatic verify_coeffs();
        classifier_pkg::weight_t rdat;
        wb_transfer(1'b1, 6'd63, 16'h5a5a, rdat);                   // Unmapped write is dropped
        for (int adr = 0; adr < classifier_pkg::N_COEFF; adr++) begin
            wb_transfer(1'b0, classifier_pkg::wb_adr_t'(adr), '0, rdat);
            check($sformatf("coeff %0d", adr), coeff_m[adr], rdat);
        end
        wb_transfer(1'b0, 6'd63, '0, rdat);
        check("unmapped 63", '0, rdat);
        wb_transfer(1'b0, classifier_pkg::wb_adr_t'(classifier_pkg::N_COEFF), '0, rdat);
        check("unmapped first", '0, rdat);
    endtask

    task automatic check_ranking(input string what, input classifier_pkg::ranked_vec_t exp);
        for (int k = 0; k < classifier_pkg::TOP_K; k++) begin
            check($sformatf("%s slot %0d score", what, k), exp[k].score, o_ranked[k].score);
            check($sformatf("%s slot %0d class", what, k), exp[k].id, o_ranked[k].id);
        end
    endtask

    task automatic run_classifier(input feat_mode_e mode);
        logic [31:0]                  bits;
        classifier_pkg::feature_vec_t vec;
        classifier_pkg::ranked_vec_t  exp;
        int                           waited;
        for (int j = 0; j < classifier_pkg::N_FEATURES; j++) begin
            if (mode == F_RANDOM) begin
                random_bits(24, bits);
                feat_m[j] = bits[23:0];
            end else begin
                feat_m[j] = (j % 2 == 0) ? 24'sh7f_ffff : 24'sh80_0000;
            end
            vec[j] = feat_m[j];
        end
        if (have_last) begin
            check_ranking("held before start", last_rank);
        end
        i_features = vec;
        i_start    = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        check("o_busy after start", 1'b1, o_busy);
        @(negedge i_clk);
        // Start empties every slot to the lowest score and class 0
        for (int k = 0; k < classifier_pkg::TOP_K; k++) begin
            check($sformatf("cleared slot %0d score", k), 32'sh8000_0000, o_ranked[k].score);
            check($sformatf("cleared slot %0d class", k), '0, o_ranked[k].id);
        end
        waited = 0;
        while (!o_done && waited < RUN_BOUND) begin
            @(negedge i_clk);
            waited++;
        end
        if (!o_done) begin
            abort_run("o_done did not arrive");
        end
        check("o_busy with o_done", 1'b0, o_busy);
        exp = rank_model();
        check_ranking("ranking", exp);
        @(negedge i_clk);
        check("o_done after pulse", 1'b0, o_done);
        check("o_busy after pulse", 1'b0, o_busy);
        repeat (4) @(negedge i_clk);
        check_ranking("held after done", exp);
        last_rank = exp;
        have_last = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Test table and main sequence

    initial begin
        tests[0] = '{"random_a", C_RANDOM, F_RANDOM};
        tests[1] = '{"bias_only", C_BIAS, F_RANDOM};
        tests[2] = '{"tie_scores", C_TIE, F_RANDOM};
        tests[3] = '{"extreme_features", C_RANDOM, F_EXTREME};
        tests[4] = '{"run_first", C_RANDOM, F_RANDOM};
        tests[5] = '{"run_second", C_KEEP, F_RANDOM};           // Same weights with new features

        lfsr       = LFSR_SEED;
        have_last  = 1'b0;
        i_rst_n    = 1'b0;
        i_start    = 1'b0;
        i_features = '0;
        i_wb       = '0;
        test_name  = "reset";

        repeat (RESET_CYCLES) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        check("o_busy", 1'b0, o_busy);
        check("o_done", 1'b0, o_done);
        check("ack", 1'b0, o_wb.ack);

        for (int t = 0; t < N_TESTS; t++) begin
            test_name = tests[t].name;
            if (tests[t].coeff != C_KEEP) begin
                load_coeffs(tests[t].coeff);
                verify_coeffs();
            end
            run_classifier(tests[t].feat);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== sim.f ====
logic/classifier_pkg.sv
logic/coeff_store.sv
logic/dense_mac.sv
logic/topk_ranker.sv
logic/classifier_seq.sv
logic/char_classifier.sv
dv/char_classifier_asserts.sv
dv/tb_char_classifier.sv
